//--- hw/intra4_pkg.sv
// Shared types and constants for the 4x4 intra luma mode decision.
// Every RTL file and the testbench pull from this package.
// Blocks are raster ordered: pixel y*4+x sits at element y*4+x, so
// row 0 occupies the low 32 bits of a block_t.

package intra4_pkg;

    // --------------------
    // Sizes
    // --------------------
    localparam int NUM_MODES  = 4;
    localparam int BLK_DIM    = 4;
    // Distortion is weighted by 256 against the header cost
    localparam int DIST_SHIFT = 8;

    // --------------------
    // Types
    // --------------------
    typedef logic [7:0] pixel_t;

    typedef pixel_t [BLK_DIM-1:0] row_t;

    typedef pixel_t [BLK_DIM*BLK_DIM-1:0] block_t;

    typedef logic [1:0]  mode_t;
    typedef logic [20:0] sse_t;
    typedef logic [15:0] lambda_t;
    typedef logic [10:0] cost_t;
    typedef logic [31:0] score_t;

    // The lower mode index wins a tie
    localparam mode_t MODE_DC = 2'd0;
    localparam mode_t MODE_TM = 2'd1;
    localparam mode_t MODE_VE = 2'd2;
    localparam mode_t MODE_HE = 2'd3;

    // Fixed header cost per mode
    localparam cost_t MODE_COST [NUM_MODES] = '{
        11'd40,
        11'd1151,
        11'd1723,
        11'd1874
    };

endpackage

//--- hw/intra4_ctx_if.sv
// Neighbour context of one 4x4 block.
// The sequencer loads it on start; the predictors only read it.

`timescale 1ns/1ps

interface intra4_ctx_if;
    import intra4_pkg::*;

    pixel_t top_left;
    row_t   top;
    // Only pixel 0 feeds the VE filter
    row_t   top_right;
    row_t   left;

    modport ctrl (output top_left, top, top_right, left);

    modport pred (input top_left, top, top_right, left);

endinterface

//--- hw/intra4_predict.sv
// Combinational DC, TM, VE and HE predictors for a 4x4 luma block.
// All four blocks are produced at once from the neighbour context.

`timescale 1ns/1ps

module intra4_predict (
    intra4_ctx_if.pred         ctx,
    output intra4_pkg::block_t pred_o [intra4_pkg::NUM_MODES]
);
    import intra4_pkg::*;

    logic [10:0] dc_sum;
    logic [10:0] dc_rnd;
    pixel_t      dc_val;
    row_t        ve_row;
    row_t        he_col;
    pixel_t      top_ext [BLK_DIM+2];
    pixel_t      left_ext [BLK_DIM+2];

    // (a + 2b + c + 2) >> 2
    function automatic pixel_t avg3(input pixel_t a, input pixel_t b, input pixel_t c);
        logic [9:0] acc;
        acc = {2'b00, a} + {1'b0, b, 1'b0} + {2'b00, c} + 10'd2;
        return acc[9:2];
    endfunction

    function automatic pixel_t clip_tm(input pixel_t l, input pixel_t t, input pixel_t tl);
        logic signed [9:0] v;
        v = $signed({2'b00, l}) + $signed({2'b00, t}) - $signed({2'b00, tl});
        if (v < 10'sd0) begin
            return 8'd0;
        end
        if (v > 10'sd255) begin
            return 8'd255;
        end
        return v[7:0];
    endfunction

    // --------------------
    // Edge extension
    // --------------------
    always_comb begin
        top_ext[0]  = ctx.top_left;
        left_ext[0] = ctx.top_left;
        for (int i = 0; i < BLK_DIM; i++) begin
            top_ext[i+1]  = ctx.top[i];
            left_ext[i+1] = ctx.left[i];
        end
        top_ext[BLK_DIM+1]  = ctx.top_right[0];
        // Bottom left repeats the last left pixel
        left_ext[BLK_DIM+1] = ctx.left[BLK_DIM-1];
    end

    // DC over four top and four left pixels
    always_comb begin
        dc_sum = '0;
        for (int i = 0; i < BLK_DIM; i++) begin
            dc_sum = dc_sum + {3'b000, ctx.top[i]} + {3'b000, ctx.left[i]};
        end
    end

    assign dc_rnd = dc_sum + 11'd4;
    assign dc_val = dc_rnd[10:3];

    // Smoothed top row and left column
    always_comb begin
        for (int i = 0; i < BLK_DIM; i++) begin
            ve_row[i] = avg3(top_ext[i], top_ext[i+1], top_ext[i+2]);
            he_col[i] = avg3(left_ext[i], left_ext[i+1], left_ext[i+2]);
        end
    end

    // --------------------
    // Block fill
    // --------------------
    always_comb begin
        for (int y = 0; y < BLK_DIM; y++) begin
            for (int x = 0; x < BLK_DIM; x++) begin
                pred_o[MODE_DC][y*BLK_DIM+x] = dc_val;
                pred_o[MODE_TM][y*BLK_DIM+x] = clip_tm(ctx.left[y], ctx.top[x],
                                                       ctx.top_left);
                pred_o[MODE_VE][y*BLK_DIM+x] = ve_row[x];
                pred_o[MODE_HE][y*BLK_DIM+x] = he_col[y];
            end
        end
    end

endmodule

//--- hw/intra4_sse.sv
// Row-serial sum of squared errors between source and one prediction.
// Pulse clear_i first, then one row_valid_i per row; the sum is valid
// the cycle after the fourth row strobe.

`timescale 1ns/1ps

module intra4_sse (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clear_i,
    input  logic               row_valid_i,
    input  logic [1:0]         row_sel_i,
    input  intra4_pkg::block_t src_i,
    input  intra4_pkg::block_t pred_i,
    output intra4_pkg::sse_t   sse_o
);
    import intra4_pkg::*;

    logic [17:0] row_sq;
    sse_t        acc_q;

    function automatic logic [15:0] sq_diff(input pixel_t a, input pixel_t b);
        pixel_t d;
        d = (a > b) ? a - b : b - a;
        return {8'h00, d} * {8'h00, d};
    endfunction

    // Four squared differences of the selected row
    always_comb begin
        row_sq = '0;
        for (int x = 0; x < BLK_DIM; x++) begin
            row_sq = row_sq + {2'b00, sq_diff(src_i[int'(row_sel_i)*BLK_DIM+x],
                                              pred_i[int'(row_sel_i)*BLK_DIM+x])};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else if (clear_i) begin
            acc_q <= '0;
        end else if (row_valid_i) begin
            acc_q <= acc_q + {3'b000, row_sq};
        end
    end

    assign sse_o = acc_q;

    // Sequencer never clears and accumulates in the same cycle
    a_clear_vs_row: assert property (@(posedge clk) disable iff (!rst_n)
        !(clear_i && row_valid_i))
        else $error("clear and row strobe together");

endmodule

//--- hw/intra4_mode_decide.sv
// Rate-distortion scoring and best mode selection.
// Score per mode is (SSE << 8) + lambda * header cost; the strict minimum
// wins, so ties keep the lower mode. Result is registered on decide_i.

`timescale 1ns/1ps

module intra4_mode_decide (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                decide_i,
    input  intra4_pkg::lambda_t lambda_i,
    input  intra4_pkg::sse_t    sse_i [intra4_pkg::NUM_MODES],
    input  intra4_pkg::block_t  pred_i [intra4_pkg::NUM_MODES],
    output intra4_pkg::mode_t   best_mode_o,
    output intra4_pkg::score_t  score_o,
    output intra4_pkg::block_t  pred_o
);
    import intra4_pkg::*;

    score_t score [NUM_MODES];
    mode_t  best_mode;
    score_t best_score;

    always_comb begin
        for (int m = 0; m < NUM_MODES; m++) begin
            score[m] = ({11'b0, sse_i[m]} << DIST_SHIFT)
                     + {16'b0, lambda_i} * {21'b0, MODE_COST[m]};
        end
    end

    // Scan upward, replace only on a strictly lower score
    always_comb begin
        best_mode  = MODE_DC;
        best_score = score[0];
        for (int m = 1; m < NUM_MODES; m++) begin
            if (score[m] < best_score) begin
                best_score = score[m];
                best_mode  = mode_t'(m);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            best_mode_o <= MODE_DC;
            score_o     <= '0;
            pred_o      <= '0;
        end else if (decide_i) begin
            best_mode_o <= best_mode;
            score_o     <= best_score;
            pred_o      <= pred_i[best_mode];
        end
    end

endmodule

//--- hw/intra4_pick_best.sv
// Top level of the 4x4 intra mode decision.
// Pulse start_i while idle with the block and its neighbours; four rows
// are scored over four cycles and done_o pulses with the best mode,
// its score and its prediction. Starts while busy are dropped.

`timescale 1ns/1ps

module intra4_pick_best (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_i,
    input  intra4_pkg::lambda_t lambda_i,
    input  intra4_pkg::block_t  src_i,
    input  intra4_pkg::pixel_t  top_left_i,
    input  intra4_pkg::row_t    top_i,
    input  intra4_pkg::row_t    top_right_i,
    input  intra4_pkg::row_t    left_i,
    output logic                done_o,
    output intra4_pkg::mode_t   best_mode_o,
    output intra4_pkg::score_t  score_o,
    output intra4_pkg::block_t  pred_o
);
    import intra4_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_ACC, ST_DEC} state_t;

    state_t     state_q;
    logic [2:0] row_cnt_q;
    logic       accept;
    logic       row_valid;
    logic       decide;
    lambda_t    lambda_q;
    block_t     src_q;
    block_t     pred [NUM_MODES];
    sse_t       sse [NUM_MODES];

    intra4_ctx_if ctx_if ();

    // --------------------
    // Sequencer
    // --------------------
    assign accept    = start_i && (state_q == ST_IDLE);
    assign row_valid = (state_q == ST_ACC);
    assign decide    = (state_q == ST_DEC);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            row_cnt_q <= '0;
            done_o    <= 1'b0;
        end else begin
            // Result lands on the same edge
            done_o <= decide;
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q   <= ST_ACC;
                        row_cnt_q <= '0;
                    end
                end
                ST_ACC: begin
                    row_cnt_q <= row_cnt_q + 3'd1;
                    if (row_cnt_q == 3'(BLK_DIM - 1)) begin
                        state_q <= ST_DEC;
                    end
                end
                ST_DEC:  state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Source, lambda and context held until the next accepted start
    always_ff @(posedge clk) begin
        if (accept) begin
            src_q            <= src_i;
            lambda_q         <= lambda_i;
            ctx_if.top_left  <= top_left_i;
            ctx_if.top       <= top_i;
            ctx_if.top_right <= top_right_i;
            ctx_if.left      <= left_i;
        end
    end

    // --------------------
    // Datapath
    // --------------------
    intra4_predict u_predict (
        .ctx    (ctx_if.pred),
        .pred_o (pred)
    );

    for (genvar m = 0; m < NUM_MODES; m++) begin : g_sse
        intra4_sse u_sse (
            .clk         (clk),
            .rst_n       (rst_n),
            .clear_i     (accept),
            .row_valid_i (row_valid),
            .row_sel_i   (row_cnt_q[1:0]),
            .src_i       (src_q),
            .pred_i      (pred[m]),
            .sse_o       (sse[m])
        );
    end

    intra4_mode_decide u_decide (
        .clk         (clk),
        .rst_n       (rst_n),
        .decide_i    (decide),
        .lambda_i    (lambda_q),
        .sse_i       (sse),
        .pred_i      (pred),
        .best_mode_o (best_mode_o),
        .score_o     (score_o),
        .pred_o      (pred_o)
    );

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |=> !done_o)
        else $error("done held longer than one cycle");

    a_row_range: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == ST_ACC) |-> (row_cnt_q <= 3'(BLK_DIM - 1)))
        else $error("row counter past last row");

endmodule

//--- test/tb_intra4_pick_best.sv
// Testbench for the 4x4 intra mode decision.
// Reads vectors from test/intra4_stimulus.txt, starts one block per vector,
// times done_o and checks mode, score and predicted block against the file.

`timescale 1ns/1ps

module tb_intra4_pick_best;
    import intra4_pkg::*;

    localparam int VEC_WORDS = 15;
    localparam int MAX_VECS  = 32;
    localparam int LATENCY   = 6;

    logic        clk;
    logic        rst_n;
    logic        start_i;
    lambda_t     lambda_i;
    block_t      src_i;
    pixel_t      top_left_i;
    row_t        top_i;
    row_t        top_right_i;
    row_t        left_i;
    logic        done_o;
    mode_t       best_mode_o;
    score_t      score_o;
    block_t      pred_o;

    logic [31:0] vec_mem [MAX_VECS*VEC_WORDS+1];
    int          num_vecs;
    logic        loaded = 1'b0;

    intra4_pick_best intra4_pick_best_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .lambda_i    (lambda_i),
        .src_i       (src_i),
        .top_left_i  (top_left_i),
        .top_i       (top_i),
        .top_right_i (top_right_i),
        .left_i      (left_i),
        .done_o      (done_o),
        .best_mode_o (best_mode_o),
        .score_o     (score_o),
        .pred_o      (pred_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // --------------------
    // Helpers
    // --------------------
    function automatic int word_base(input int idx);
        return 1 + idx * VEC_WORDS;
    endfunction

    // Four row words with row 0 first
    function automatic block_t block_from(input int at);
        return {vec_mem[at+3], vec_mem[at+2], vec_mem[at+1], vec_mem[at]};
    endfunction

    task automatic stop_on_failure();
        $display("TB FAILED");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_mode(input string name, input mode_t exp, input mode_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_score(input string name, input score_t exp, input score_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_block(input string name, input block_t exp, input block_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic drive_inputs(input int idx);
        int b;
        b = word_base(idx);
        lambda_i    <= lambda_t'(vec_mem[b]);
        top_left_i  <= pixel_t'(vec_mem[b+1]);
        top_i       <= vec_mem[b+2];
        top_right_i <= vec_mem[b+3];
        left_i      <= vec_mem[b+4];
        src_i       <= block_from(b+5);
    endtask

    // One block; with intrude set a second start from vector other
    // is sampled two cycles after the first and must be dropped
    task automatic run_vector(input int idx, input bit intrude, input int other);
        int b;
        int cycles;
        bit seen;
        b = word_base(idx);
        @(posedge clk);
        drive_inputs(idx);
        start_i <= 1'b1;
        // Edge that samples the start
        @(posedge clk);
        start_i <= 1'b0;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 4 * LATENCY) begin
            @(negedge clk);
            cycles++;
            if (done_o) begin
                seen = 1'b1;
            end else if (intrude && cycles == 1) begin
                @(posedge clk);
                drive_inputs(other);
                start_i <= 1'b1;
            end else if (intrude && cycles == 2) begin
                @(posedge clk);
                start_i <= 1'b0;
            end
        end
        if (!seen) begin
            $display("done_o never rose for vector %0d", idx);
            stop_on_failure();
        end
        check_count("done_o latency", LATENCY, cycles);
        check_mode("best_mode_o", mode_t'(vec_mem[b+9]), best_mode_o);
        check_score("score_o", vec_mem[b+10], score_o);
        check_block("pred_o", block_from(b+11), pred_o);
        repeat (intrude ? 8 : 1) begin
            @(negedge clk);
            check_flag("done_o", 1'b0, done_o);
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        rst_n       = 1'b0;
        start_i     = 1'b0;
        lambda_i    = '0;
        src_i       = '0;
        top_left_i  = '0;
        top_i       = '0;
        top_right_i = '0;
        left_i      = '0;
        $readmemh("test/intra4_stimulus.txt", vec_mem);
        num_vecs = int'(vec_mem[0]);
        if (num_vecs < 3 || num_vecs > MAX_VECS) begin
            $display("stimulus file does not hold a usable vector count");
            stop_on_failure();
        end
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("done_o", 1'b0, done_o);
        check_mode("best_mode_o", '0, best_mode_o);
        check_score("score_o", '0, score_o);
        check_block("pred_o", '0, pred_o);
        for (int i = 0; i < num_vecs; i++) begin
            run_vector(i, 1'b0, 0);
        end
        // Start while busy carries vector 2 and is dropped
        run_vector(1, 1'b1, 2);
        $display("TB PASSED");
        $finish;
    end

    initial begin
        wait (loaded);
        #((num_vecs * 20 + 50) * 4);
        $display("watchdog expired before all vectors finished");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

endmodule

//--- test/intra4_stimulus.txt
// 4x4 intra mode decision vectors in hex. First word is the vector count.
// Per vector, line 1: lambda top_left top top_right left src_row0..src_row3
// line 2: best_mode score pred_row0..pred_row3 (pixel x=0 in the low byte)
7
// DC wins, lambda 0
0000 50 A08C7864 D2C8BEB4 1E32465A 60606060 60606060 60606060 60606060
0 00001000 5F5F5F5F 5F5F5F5F 5F5F5F5F 5F5F5F5F
// TM wins on an exact match, small lambda
0002 50 A08C7864 D2C8BEB4 1E32465A AA96826E 96826E5A 826E5A46 6E5A4632
1 000008FE AA96826E 96826E5A 826E5A46 6E5A4632
// VE wins, one pixel off by one
0000 50 A08C7864 D2C8BEB4 1E32465A A08C7865 A08C7864 A08C7864 A08C7864
2 00000100 A08C7864 A08C7864 A08C7864 A08C7864
// HE wins, one pixel off by two
0000 50 A08C7864 D2C8BEB4 1E32465A 53535353 46464646 32323232 25232323
3 00000400 53535353 46464646 32323232 23232323
// Large lambda, DC beats an exact VE match on header cost
FFFF 50 A08C7864 D2C8BEB4 1E32465A A08C7864 A08C7864 A08C7864 A08C7864
0 0093CFD8 5F5F5F5F 5F5F5F5F 5F5F5F5F 5F5F5F5F
// TM and VE tie on SSE, lower index wins
0000 50 A08C7864 D2C8BEB4 1E32465A A5917D69 9B87735F 917D6955 87735F4B
1 000E1000 AA96826E 96826E5A 826E5A46 6E5A4632
// TM clipped at both ends
0000 20 3CFAC80A 00000000 148005F0 FFFFFFDA 21DFAD00 9CFFFF6A 30EEBC00
1 00000000 FFFFFFDA 21DFAD00 9CFFFF6A 30EEBC00

//--- flist.f
hw/intra4_pkg.sv
hw/intra4_ctx_if.sv
hw/intra4_predict.sv
hw/intra4_sse.sv
hw/intra4_mode_decide.sv
hw/intra4_pick_best.sv
test/tb_intra4_pick_best.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_intra4_pick_best -Mdir obj_dir

./obj_dir/Vtb_intra4_pick_best 2>&1 | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
